// File: dbg_pkg.sv
package dbg_pkg;

    localparam int DATA_W       = 8;
    localparam int WORD_W       = 32;
    localparam int CLKS_PER_BIT = 8;
    localparam int FIFO_DEPTH   = 16;
    localparam int IMEM_AW      = 8;     // 256 program words
    localparam int REG_AW       = 5;     // 32 registers, 32 data words

    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);
    localparam int FIFO_AW      = $clog2(FIFO_DEPTH);

    // Host command bytes
    localparam logic [DATA_W-1:0] CMD_START = 8'h07;
    localparam logic [DATA_W-1:0] CMD_LOAD  = 8'hFE;
    localparam logic [DATA_W-1:0] CMD_DEBUG = 8'hFC;
    localparam logic [DATA_W-1:0] CMD_RUN   = 8'hF0;
    localparam logic [DATA_W-1:0] CMD_NEXT  = 8'h01;
    localparam logic [DATA_W-1:0] CMD_END   = 8'hF8;

    typedef enum logic [3:0] {
        IDLE,
        GET_CMD,
        LOAD_SIZE,
        LOAD_BYTE,
        WRITE_INST,
        STEP_WAIT,
        STEP_PULSE,
        RUN,
        DUMP_REG,
        DUMP_MEM,
        DUMP_PC
    } dbg_state_t;

endpackage

// File: fifo_if.sv
`timescale 1ns/1ps

interface fifo_if;
    import dbg_pkg::*;

    logic              wr;
    logic [DATA_W-1:0] wdata;
    logic              rd;
    logic [DATA_W-1:0] rdata;   // Head entry, valid while not empty
    logic              empty;
    logic              full;

    modport writer (
        output wr, wdata,
        input  full
    );

    modport reader (
        output rd,
        input  rdata, empty
    );

    modport storage (
        input  wr, wdata, rd,
        output rdata, empty, full
    );

endinterface

// File: byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo (
    input  logic    i_clock,
    input  logic    i_reset,
    fifo_if.storage fifo
);
    import dbg_pkg::*;

    logic [DATA_W-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_wr;
    logic               do_rd;

    assign do_wr = fifo.wr && !fifo.full;
    assign do_rd = fifo.rd && !fifo.empty;

    assign fifo.rdata = mem[rd_ptr];            // Fall-through head
    assign fifo.empty = (count == '0);
    assign fifo.full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

    always_ff @(posedge i_clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= fifo.wdata;
        end
    end

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;        // Wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle or both
            endcase
        end
    end

    // Writers and readers must respect the flags themselves
    assert property (@(posedge i_clock) disable iff (i_reset)
        !(fifo.wr && fifo.full));

    assert property (@(posedge i_clock) disable iff (i_reset)
        !(fifo.rd && fifo.empty));

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic   i_clock,
    input  logic   i_reset,
    input  logic   i_rx,
    fifo_if.writer fifo
);
    import dbg_pkg::*;

    logic                 rx_meta;
    logic                 rx_sync;
    logic                 busy;
    logic [BIT_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_cnt;      // 0 start, 1..8 data, 9 stop
    logic [DATA_W-1:0]    shift;
    logic                 wr;
    logic                 sample;

    assign sample     = busy && (clk_cnt == '0);
    assign fifo.wr    = wr;
    assign fifo.wdata = shift;

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            wr      <= 1'b0;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            wr      <= 1'b0;
            if (!busy) begin
                if (!rx_sync) begin                 // Start bit edge
                    busy    <= 1'b1;
                    clk_cnt <= BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);
                    bit_cnt <= '0;
                end
            end else if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= BIT_CNT_W'(CLKS_PER_BIT - 1);
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd0 && rx_sync) begin
                    busy <= 1'b0;                   // Glitch, not a start bit
                end else if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                    wr   <= rx_sync && !fifo.full;  // Drop on bad stop or full
                end
            end
        end
    end

    // LSB arrives first
    always_ff @(posedge i_clock) begin
        if (sample && bit_cnt inside {[4'd1:4'd8]}) begin
            shift <= {rx_sync, shift[DATA_W-1:1]};
        end
    end

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic   i_clock,
    input  logic   i_reset,
    fifo_if.reader fifo,
    output logic   o_tx
);
    import dbg_pkg::*;

    logic                 busy;
    logic [BIT_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_cnt;
    logic [DATA_W:0]      shift;       // Data plus stop bit
    logic                 bit_end;

    assign fifo.rd = !busy && !fifo.empty;
    assign bit_end = busy && (clk_cnt == '0);

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            busy    <= 1'b0;
            o_tx    <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (fifo.rd) begin
            busy    <= 1'b1;
            o_tx    <= 1'b0;                    // Start bit
            clk_cnt <= BIT_CNT_W'(CLKS_PER_BIT - 1);
            bit_cnt <= '0;
        end else if (busy) begin
            if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= BIT_CNT_W'(CLKS_PER_BIT - 1);
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;               // Stop bit done, line stays high
                end else begin
                    o_tx    <= shift[0];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (fifo.rd) begin
            shift <= {1'b1, fifo.rdata};
        end else if (bit_end) begin
            shift <= {1'b1, shift[DATA_W:1]};
        end
    end

endmodule

// File: debug_unit.sv
`timescale 1ns/1ps

module debug_unit (
    input  logic                        i_clock,
    input  logic                        i_reset,
    fifo_if.reader                      rx,
    fifo_if.writer                      tx,
    input  logic                        i_halt,
    input  logic [dbg_pkg::WORD_W-1:0]  i_pc,
    input  logic [dbg_pkg::WORD_W-1:0]  i_reg_data,
    input  logic [dbg_pkg::WORD_W-1:0]  i_mem_data,
    output logic [dbg_pkg::REG_AW-1:0]  o_reg_addr,
    output logic [dbg_pkg::REG_AW-1:0]  o_mem_addr,
    output logic                        o_mem_read,
    output logic                        o_imem_we,
    output logic [dbg_pkg::IMEM_AW-1:0] o_imem_addr,
    output logic [dbg_pkg::WORD_W-1:0]  o_imem_data,
    output logic                        o_core_enable
);
    import dbg_pkg::*;

    dbg_state_t         state;
    dbg_state_t         state_next;
    logic [1:0]         lane;          // Byte within the current word
    logic [REG_AW-1:0]  entry;         // Register or memory index in dump
    logic [IMEM_AW-1:0] word_cnt;
    logic [DATA_W-1:0]  size;
    logic               step_mode;
    logic [WORD_W-1:0]  inst_word;
    logic [WORD_W-1:0]  dump_word;

    // Pop only in states that consume a byte
    assign rx.rd = !rx.empty &&
                   (state inside {IDLE, GET_CMD, LOAD_SIZE, LOAD_BYTE, STEP_WAIT});
    assign tx.wr = !tx.full && (state inside {DUMP_REG, DUMP_MEM, DUMP_PC});
    assign tx.wdata = dump_word[8*lane +: DATA_W];

    assign o_reg_addr    = entry;
    assign o_mem_addr    = entry;
    assign o_mem_read    = (state == DUMP_MEM);
    assign o_imem_we     = (state == WRITE_INST);
    assign o_imem_addr   = word_cnt;
    assign o_imem_data   = inst_word;
    assign o_core_enable = (state == STEP_PULSE) || (state == RUN && !i_halt);

    always_comb begin
        case (state)
            DUMP_MEM: dump_word = i_mem_data;
            DUMP_PC:  dump_word = i_pc;
            default:  dump_word = i_reg_data;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (rx.rd && rx.rdata == CMD_START) begin
                    state_next = GET_CMD;
                end
            end
            GET_CMD: begin
                if (rx.rd) begin
                    case (rx.rdata)
                        CMD_LOAD:  state_next = LOAD_SIZE;
                        CMD_DEBUG: state_next = STEP_WAIT;
                        CMD_RUN:   state_next = RUN;
                        default:   state_next = IDLE;   // Unknown command
                    endcase
                end
            end
            LOAD_SIZE: begin
                if (rx.rd) begin
                    state_next = (rx.rdata == '0) ? IDLE : LOAD_BYTE;
                end
            end
            LOAD_BYTE: begin
                if (rx.rd && lane == 2'd3) begin
                    state_next = WRITE_INST;
                end
            end
            WRITE_INST: begin
                state_next = (word_cnt + 1'b1 == size) ? IDLE : LOAD_BYTE;
            end
            STEP_WAIT: begin
                if (rx.rd && rx.rdata == CMD_NEXT) begin
                    state_next = STEP_PULSE;
                end else if (rx.rd && rx.rdata == CMD_END) begin
                    state_next = IDLE;
                end
            end
            STEP_PULSE: state_next = DUMP_REG;
            RUN: begin
                if (i_halt) begin
                    state_next = DUMP_REG;
                end
            end
            DUMP_REG: begin
                if (tx.wr && lane == 2'd3 && entry == '1) begin
                    state_next = DUMP_MEM;
                end
            end
            DUMP_MEM: begin
                if (tx.wr && lane == 2'd3 && entry == '1) begin
                    state_next = DUMP_PC;
                end
            end
            DUMP_PC: begin
                if (tx.wr && lane == 2'd3) begin
                    state_next = step_mode ? STEP_WAIT : IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            state     <= IDLE;
            lane      <= '0;
            entry     <= '0;
            word_cnt  <= '0;
            size      <= '0;
            step_mode <= 1'b0;
        end else begin
            state <= state_next;
            if (rx.rd && state == GET_CMD) begin
                step_mode <= (rx.rdata == CMD_DEBUG);
            end
            if (rx.rd && state == LOAD_SIZE) begin
                size     <= rx.rdata;
                word_cnt <= '0;
                lane     <= '0;
            end
            if (rx.rd && state == LOAD_BYTE) begin
                lane <= lane + 1'b1;
            end
            if (state == WRITE_INST) begin
                word_cnt <= word_cnt + 1'b1;
            end
            if (tx.wr) begin
                lane <= lane + 1'b1;
                if (lane == 2'd3 && state != DUMP_PC) begin
                    entry <= entry + 1'b1;          // Wraps between sections
                end
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (rx.rd && state == LOAD_BYTE) begin
            inst_word[8*lane +: DATA_W] <= rx.rdata;    // LSB first
        end
    end

    // Program writes stay inside the announced size
    assert property (@(posedge i_clock) disable iff (i_reset)
        o_imem_we |-> (o_imem_addr < size));

    // Every dump starts at register 0, byte 0
    assert property (@(posedge i_clock) disable iff (i_reset)
        $rose(state == DUMP_REG) |-> (lane == '0 && entry == '0));

endmodule

// File: inst_mem.sv
`timescale 1ns/1ps

module inst_mem (
    input  logic                        i_clock,
    input  logic                        i_we,
    input  logic [dbg_pkg::IMEM_AW-1:0] i_waddr,
    input  logic [dbg_pkg::WORD_W-1:0]  i_wdata,
    input  logic [dbg_pkg::IMEM_AW-1:0] i_raddr,
    output logic [dbg_pkg::WORD_W-1:0]  o_rdata
);
    import dbg_pkg::*;

    logic [WORD_W-1:0] mem [2**IMEM_AW];

    // Debug load port
    always_ff @(posedge i_clock) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata = mem[i_raddr];          // Async fetch

endmodule

// File: debug_top.sv
`timescale 1ns/1ps

module debug_top (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_rx,
    output logic                        o_tx,
    input  logic                        i_halt,
    input  logic [dbg_pkg::WORD_W-1:0]  i_pc,
    input  logic [dbg_pkg::WORD_W-1:0]  i_reg_data,
    input  logic [dbg_pkg::WORD_W-1:0]  i_mem_data,
    output logic [dbg_pkg::REG_AW-1:0]  o_reg_addr,
    output logic [dbg_pkg::REG_AW-1:0]  o_mem_addr,
    output logic                        o_mem_read,
    output logic                        o_core_enable,
    input  logic [dbg_pkg::IMEM_AW-1:0] i_fetch_addr,
    output logic [dbg_pkg::WORD_W-1:0]  o_fetch_inst
);
    import dbg_pkg::*;

    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    logic [WORD_W-1:0]  imem_data;

    fifo_if rx_link ();     // Host to controller
    fifo_if tx_link ();     // Controller to host

    uart_rx uart_rx_i (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .fifo    (rx_link)
    );

    byte_fifo rx_fifo_i (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .fifo    (rx_link)
    );

    debug_unit debug_unit_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .rx            (rx_link),
        .tx            (tx_link),
        .i_halt        (i_halt),
        .i_pc          (i_pc),
        .i_reg_data    (i_reg_data),
        .i_mem_data    (i_mem_data),
        .o_reg_addr    (o_reg_addr),
        .o_mem_addr    (o_mem_addr),
        .o_mem_read    (o_mem_read),
        .o_imem_we     (imem_we),
        .o_imem_addr   (imem_addr),
        .o_imem_data   (imem_data),
        .o_core_enable (o_core_enable)
    );

    byte_fifo tx_fifo_i (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .fifo    (tx_link)
    );

    uart_tx uart_tx_i (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .fifo    (tx_link),
        .o_tx    (o_tx)
    );

    inst_mem inst_mem_i (
        .i_clock (i_clock),
        .i_we    (imem_we),
        .i_waddr (imem_addr),
        .i_wdata (imem_data),
        .i_raddr (i_fetch_addr),
        .o_rdata (o_fetch_inst)
    );

endmodule

// File: tb_debug_top.sv
`timescale 1ns/1ps

module tb_debug_top;
    import dbg_pkg::*;

    localparam int NUM_ROWS   = 9;
    localparam int WAIT_LIMIT = 2000;                   // Cycles per wait loop
    localparam int QUIET      = 40 * CLKS_PER_BIT;      // Silence window
    localparam int DUMP_WORDS = 65;                     // 32 regs, 32 mem, PC

    typedef struct packed {
        int              n_cmd;
        logic [2:0][7:0] cmd;                           // cmd[0] goes first
        int              n_words;                       // Program words after cmd
        int              exp_en;                        // Enable cycles or cycles to halt
        bit              until_halt;
        bit              dump;
    } row_t;

    logic               i_clock;
    logic               i_reset;
    logic               i_rx;
    logic               o_tx;
    logic               i_halt;
    logic [WORD_W-1:0]  i_pc;
    logic [WORD_W-1:0]  i_reg_data;
    logic [WORD_W-1:0]  i_mem_data;
    logic [REG_AW-1:0]  o_reg_addr;
    logic [REG_AW-1:0]  o_mem_addr;
    logic               o_mem_read;
    logic               o_core_enable;
    logic [IMEM_AW-1:0] i_fetch_addr;
    logic [WORD_W-1:0]  o_fetch_inst;

    int                 enable_seen;
    integer             seed;
    row_t               rows [NUM_ROWS];
    logic [WORD_W-1:0]  program_words [8];

    debug_top dut_i (.*);

    always #20 i_clock = ~i_clock;

    // Core model reads are combinational
    assign i_reg_data = 32'hA500_0000 + 32'(o_reg_addr);
    assign i_mem_data = o_mem_read ? (32'h5A00_0000 + 32'(o_mem_addr) * 32'd3)
                                   : 32'h0000_0000;    // Data memory needs the read strobe

    initial begin
        i_pc = '0;
        forever begin
            @(posedge i_clock);
            if (i_reset) begin
                i_pc <= '0;
            end else if (o_core_enable) begin
                i_pc <= i_pc + 32'd1;                   // One instruction per enable
            end
        end
    end

    initial begin
        enable_seen = 0;
        forever begin
            @(negedge i_clock);
            if (!i_reset && o_core_enable) begin
                enable_seen = enable_seen + 1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, expected);
            $display(">>> FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display(">>> FAIL");
        $fatal(1, "Timeout");
    endtask

    function automatic row_t make_row(int n_cmd, logic [7:0] b0, logic [7:0] b1,
                                      logic [7:0] b2, int n_words, int exp_en,
                                      bit until_halt, bit dump);
        row_t row;
        row.n_cmd      = n_cmd;
        row.cmd[0]     = b0;
        row.cmd[1]     = b1;
        row.cmd[2]     = b2;
        row.n_words    = n_words;
        row.exp_en     = exp_en;
        row.until_halt = until_halt;
        row.dump       = dump;
        return row;
    endfunction

    // 8N1 frame sent LSB first
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge i_clock);
            i_rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge i_clock);
        end
    endtask

    task automatic send_row(input row_t row);
        int i;
        int k;
        for (i = 0; i < row.n_cmd; i++) begin
            send_byte(row.cmd[i]);
        end
        for (i = 0; i < row.n_words; i++) begin
            for (k = 0; k < 4; k++) begin
                send_byte(program_words[i][8*k +: 8]);
            end
        end
    endtask

    task automatic receive_byte(output logic [7:0] data);
        int waited;
        int i;
        waited = 0;
        @(negedge i_clock);
        while (o_tx) begin
            if (waited == WAIT_LIMIT) begin
                report_timeout("a start bit on o_tx");
            end
            waited++;
            @(negedge i_clock);
        end
        repeat (CLKS_PER_BIT / 2) @(negedge i_clock);  // Middle of start bit
        for (i = 0; i < DATA_W; i++) begin
            repeat (CLKS_PER_BIT) @(negedge i_clock);
            data[i] = o_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge i_clock);
        check_value("o_tx stop bit", 32'(o_tx), 32'd1);
    endtask

    task automatic receive_dump(input logic [31:0] pc_expected);
        logic [7:0]  b;
        logic [31:0] word;
        int          e;
        int          k;
        for (e = 0; e < DUMP_WORDS; e++) begin
            for (k = 0; k < 4; k++) begin
                receive_byte(b);
                word[8*k +: 8] = b;
            end
            if (e < 32) begin
                check_value($sformatf("o_tx dump reg[%0d]", e), word, 32'hA500_0000 + e);
            end else if (e < 64) begin
                check_value($sformatf("o_tx dump mem[%0d]", e - 32), word,
                            32'h5A00_0000 + 32'((e - 32) * 3));
            end else begin
                check_value("o_tx dump pc", word, pc_expected);
            end
        end
    endtask

    task automatic raise_halt_after(input int cycles);
        int waited;
        int i;
        waited = 0;
        @(negedge i_clock);
        while (!o_core_enable) begin
            if (waited == WAIT_LIMIT) begin
                report_timeout("o_core_enable to rise in free run");
            end
            waited++;
            @(negedge i_clock);
        end
        for (i = 1; i < cycles; i++) begin
            @(negedge i_clock);
            check_value("o_core_enable", 32'(o_core_enable), 32'd1);
        end
        @(posedge i_clock);
        i_halt <= 1'b1;
    endtask

    task automatic check_lines_idle(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge i_clock);
            check_value("o_tx", 32'(o_tx), 32'd1);
            check_value("o_core_enable", 32'(o_core_enable), 32'd0);
            check_value("o_mem_read", 32'(o_mem_read), 32'd0);
        end
    endtask

    task automatic check_program(input int count);
        int a;
        for (a = 0; a < count; a++) begin
            @(posedge i_clock);
            i_fetch_addr <= IMEM_AW'(a);
            @(negedge i_clock);
            check_value($sformatf("o_fetch_inst[%0d]", a), o_fetch_inst, program_words[a]);
        end
    endtask

    initial begin
        int          r;
        int          w;
        int          en_before;
        logic [31:0] expected_pc;
        row_t        row;
        i_clock      = 1'b0;
        i_reset      = 1'b1;
        i_rx         = 1'b1;
        i_halt       = 1'b0;
        i_fetch_addr = '0;
        seed         = 32'h6845_f1c4;
        expected_pc  = '0;

        rows[0] = make_row(3, CMD_START, CMD_LOAD, 8'd6, 6, 0, 1'b0, 1'b0);
        rows[1] = make_row(2, CMD_START, CMD_DEBUG, 8'h00, 0, 0, 1'b0, 1'b0);
        rows[2] = make_row(1, CMD_NEXT, 8'h00, 8'h00, 0, 1, 1'b0, 1'b1);
        rows[3] = make_row(1, CMD_NEXT, 8'h00, 8'h00, 0, 1, 1'b0, 1'b1);
        rows[4] = make_row(1, CMD_NEXT, 8'h00, 8'h00, 0, 1, 1'b0, 1'b1);
        rows[5] = make_row(1, CMD_END, 8'h00, 8'h00, 0, 0, 1'b0, 1'b0);
        rows[6] = make_row(2, CMD_START, CMD_RUN, 8'h00, 0, 100, 1'b1, 1'b1);
        rows[7] = make_row(2, CMD_START, 8'h3C, 8'h00, 0, 0, 1'b0, 1'b0);  // Unknown
        rows[8] = make_row(3, CMD_START, CMD_LOAD, 8'd2, 2, 0, 1'b0, 1'b0);

        repeat (4) @(posedge i_clock);
        i_reset <= 1'b0;
        check_lines_idle(50);

        for (r = 0; r < NUM_ROWS; r++) begin
            row = rows[r];
            for (w = 0; w < row.n_words; w++) begin
                program_words[w] = $random(seed);
            end
            en_before = enable_seen;
            fork
                send_row(row);
                if (row.until_halt) raise_halt_after(row.exp_en);
                if (row.dump) receive_dump(expected_pc + 32'(row.exp_en));
            join
            expected_pc = expected_pc + 32'(row.exp_en);
            if (row.until_halt) begin
                @(posedge i_clock);
                i_halt <= 1'b0;
            end
            if (row.n_words > 0) begin
                repeat (2 * CLKS_PER_BIT) @(posedge i_clock);   // Last word settles
                check_program(row.n_words);
            end else if (!row.dump) begin
                check_lines_idle(QUIET);
            end
            check_value($sformatf("o_core_enable cycles row %0d", r),
                        32'(enable_seen - en_before), 32'(row.exp_en));
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: all.f
dbg_pkg.sv
fifo_if.sv
byte_fifo.sv
uart_rx.sv
uart_tx.sv
debug_unit.sv
inst_mem.sv
debug_top.sv
tb_debug_top.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the simulation log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f all.f --top-module tb_debug_top -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation finished without failure"
exit 0
